/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f rv_alu_unit.f --top-module rv_alu_unit_tb -Mdir obj_dir

run: compile
	./obj_dir/Vrv_alu_unit_tb | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* riscv_alu.sv */
// ---------------------------------------------------------------------
// Combinational integer ALU, zero cycles
// Shifts use only the low log2(XLEN) bits of operand b
// Operand b already carries the immediate for OP-IMM and LUI
// ---------------------------------------------------------------------

module riscv_alu
  import rv_alu_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  alu_op_e         alu_op_i,
  input  logic [XLEN-1:0] alu_a_i,
  input  logic [XLEN-1:0] alu_b_i,
  output logic [XLEN-1:0] alu_result_o
);

  localparam int SHAMT_W = $clog2(XLEN);

  logic [SHAMT_W-1:0] shamt;

  assign shamt = alu_b_i[SHAMT_W-1:0];  // Upper bits ignored

  always_comb
  begin
    case (alu_op_i)
      // ---------------------------------------------------------------------
      // Arithmetic, wraps on overflow
      // ---------------------------------------------------------------------
      ALU_ADD:    alu_result_o = alu_a_i + alu_b_i;
      ALU_SUB:    alu_result_o = alu_a_i - alu_b_i;

      // Compares return one or zero
      ALU_SLT:    alu_result_o = XLEN'($signed(alu_a_i) < $signed(alu_b_i));
      ALU_SLTU:   alu_result_o = XLEN'(alu_a_i < alu_b_i);

      // ---------------------------------------------------------------------
      // Logical
      // ---------------------------------------------------------------------
      ALU_AND:    alu_result_o = alu_a_i & alu_b_i;
      ALU_OR:     alu_result_o = alu_a_i | alu_b_i;
      ALU_XOR:    alu_result_o = alu_a_i ^ alu_b_i;

      // Shifts
      ALU_SLL:    alu_result_o = alu_a_i << shamt;
      ALU_SRL:    alu_result_o = alu_a_i >> shamt;
      ALU_SRA:    alu_result_o = $signed(alu_a_i) >>> shamt;  // Sign fill

      ALU_PASS_B: alu_result_o = alu_b_i;   // LUI
      default:    alu_result_o = '0;
    endcase
  end

endmodule

/* rv_alu_decode.sv */
// ---------------------------------------------------------------------
// Four-phase receiver and RV32I field decode, one item deep
// Source must hold instr/rs1/rs2 stable while req_i is high
// Unknown opcodes give the illegal flag with rd forced to zero
// ---------------------------------------------------------------------

module rv_alu_decode
  import rv_alu_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_i,
  input  logic [INSTR_W-1:0] instr_i,
  input  logic [XLEN-1:0]    rs1_val_i,
  input  logic [XLEN-1:0]    rs2_val_i,
  input  logic               iss_taken_i,
  output logic               ack_o,
  output logic               iss_valid_o,
  output alu_op_e            iss_op_o,
  output logic [XLEN-1:0]    iss_a_o,
  output logic [XLEN-1:0]    iss_b_o,
  output logic [4:0]         iss_rd_o,
  output logic               iss_illegal_o
);

  localparam int SHAMT_W = $clog2(XLEN);

  dec_state_e      state_q;
  rv_opcode_e      opcode;
  logic [2:0]      funct3;
  logic            alt;        // funct7 bit 5
  logic            can_load;   // Slot free now or freed this cycle
  logic            load;
  alu_op_e         op_d;
  logic [XLEN-1:0] b_d;
  logic            illegal_d;

  assign opcode   = rv_opcode_e'(instr_i[6:0]);
  assign funct3   = instr_i[14:12];
  assign alt      = instr_i[30];
  assign can_load = !iss_valid_o || iss_taken_i;
  assign load     = req_i && can_load && (state_q != DEC_ACK);
  assign ack_o    = (state_q == DEC_ACK);

  // ---------------------------------------------------------------------
  // Field decode and immediate generation
  // ---------------------------------------------------------------------
  always_comb
  begin
    op_d      = ALU_ADD;
    b_d       = rs2_val_i;
    illegal_d = 1'b0;
    case (opcode)
      OPC_OP, OPC_OP_IMM:
      begin
        case (funct3)
          3'b000:  op_d = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;  // No SUBI
          3'b001:  op_d = ALU_SLL;
          3'b010:  op_d = ALU_SLT;
          3'b011:  op_d = ALU_SLTU;
          3'b100:  op_d = ALU_XOR;
          3'b101:  op_d = alt ? ALU_SRA : ALU_SRL;
          3'b110:  op_d = ALU_OR;
          default: op_d = ALU_AND;
        endcase
        if (opcode == OPC_OP_IMM)
        begin
          if (funct3 == 3'b001 || funct3 == 3'b101)
            b_d = XLEN'(instr_i[20 +: SHAMT_W]);     // Shift amount field only
          else
            b_d = XLEN'($signed(instr_i[31:20]));    // Sign-extended I-imm
        end
      end
      OPC_LUI:
      begin
        op_d = ALU_PASS_B;
        b_d  = XLEN'($signed({instr_i[31:12], 12'b0}));  // U-imm, low 12 bits zero
      end
      default: illegal_d = 1'b1;
    endcase
  end

  // Handshake FSM and item valid
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q     <= DEC_IDLE;
      iss_valid_o <= 1'b0;
    end
    else
    begin
      case (state_q)
        DEC_IDLE:
        begin
          if (req_i)
            state_q <= can_load ? DEC_ACK : DEC_FULL;
        end
        DEC_FULL:
        begin
          if (can_load)
            state_q <= DEC_ACK;
        end
        default:
        begin
          if (!req_i)
            state_q <= DEC_IDLE;  // Ack drops after req is seen low
        end
      endcase
      if (load)
        iss_valid_o <= 1'b1;
      else if (iss_taken_i)
        iss_valid_o <= 1'b0;
    end
  end

  // Held item, qualified by iss_valid_o
  always_ff @(posedge clk_i)
  begin
    if (load)
    begin
      iss_op_o      <= op_d;
      iss_a_o       <= rs1_val_i;
      iss_b_o       <= b_d;
      iss_rd_o      <= illegal_d ? 5'd0 : instr_i[11:7];
      iss_illegal_o <= illegal_d;
    end
  end

endmodule

/* rv_alu_pkg.sv */
// ---------------------------------------------------------------------
// Shared encodings for the RV32I execution slice
// Only OP, OP-IMM and LUI major opcodes are recognized
// XLEN is not defined here. It is a module parameter of the top level
// ---------------------------------------------------------------------

package rv_alu_pkg;

  // Instruction encoding is fixed by the ISA
  localparam int INSTR_W = 32;

  // ---------------------------------------------------------------------
  // Major opcodes, instr[6:0]
  // ---------------------------------------------------------------------
  typedef enum logic [6:0]
  {
    OPC_OP     = 7'b0110011,  // Register-register
    OPC_OP_IMM = 7'b0010011,  // Register-immediate
    OPC_LUI    = 7'b0110111   // Upper immediate
  } rv_opcode_e;

  // ---------------------------------------------------------------------
  // ALU operations
  // ---------------------------------------------------------------------
  typedef enum logic [3:0]
  {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLT    = 4'd2,   // Signed compare
    ALU_SLTU   = 4'd3,   // Unsigned compare
    ALU_XOR    = 4'd4,
    ALU_OR     = 4'd5,
    ALU_AND    = 4'd6,
    ALU_SLL    = 4'd7,
    ALU_SRL    = 4'd8,
    ALU_SRA    = 4'd9,
    ALU_PASS_B = 4'd10   // LUI, immediate already in place
  } alu_op_e;

  // Upstream receiver states
  typedef enum logic [1:0]
  {
    DEC_IDLE = 2'd0,  // Waiting for req
    DEC_ACK  = 2'd1,  // Ack high, waiting for req to fall
    DEC_FULL = 2'd2   // Req seen, item slot still occupied
  } dec_state_e;

endpackage

/* rv_alu_result.sv */
// ---------------------------------------------------------------------
// One-deep result register and four-phase sender
// Sink raises res_ack_i, then drops it after res_req_o falls
// Slot is free again only once res_ack_i is seen low
// ---------------------------------------------------------------------

module rv_alu_result
#(
  parameter int XLEN = 32
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            iss_valid_i,
  input  logic [XLEN-1:0] alu_value_i,
  input  logic [4:0]      iss_rd_i,
  input  logic            iss_illegal_i,
  input  logic            res_ack_i,
  output logic            iss_taken_o,
  output logic            res_req_o,
  output logic [XLEN-1:0] res_value_o,
  output logic [4:0]      res_rd_o,
  output logic            res_illegal_o
);

  typedef enum logic [1:0]
  {
    RES_EMPTY = 2'd0,
    RES_OFFER = 2'd1,  // Req high
    RES_WAIT  = 2'd2   // Req low, ack still high
  } res_state_e;

  res_state_e state_q;

  assign iss_taken_o = (state_q == RES_EMPTY) && iss_valid_i;
  assign res_req_o   = (state_q == RES_OFFER);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q       <= RES_EMPTY;
      res_illegal_o <= 1'b0;
    end
    else
    begin
      case (state_q)
        RES_EMPTY:
        begin
          if (iss_valid_i)
          begin
            state_q       <= RES_OFFER;
            res_illegal_o <= iss_illegal_i;
          end
        end
        RES_OFFER:
        begin
          if (res_ack_i)
            state_q <= RES_WAIT;
        end
        default:
        begin
          if (!res_ack_i)
            state_q <= RES_EMPTY;
        end
      endcase
    end
  end

  // Payload, zero value for an illegal item
  always_ff @(posedge clk_i)
  begin
    if (iss_taken_o)
    begin
      res_value_o <= iss_illegal_i ? '0 : alu_value_i;
      res_rd_o    <= iss_rd_i;
    end
  end

endmodule

/* rv_alu_unit.f */
rv_alu_pkg.sv
riscv_alu.sv
rv_alu_decode.sv
rv_alu_result.sv
rv_alu_unit.sv
rv_alu_unit_chk.sv
rv_alu_unit_tb.sv

/* rv_alu_unit.sv */
// ---------------------------------------------------------------------
// Execution slice top, decode then ALU then result
// Two items in flight at most, results leave in arrival order
// Unstalled latency is 2 edges from sampled req_i to res_req_o
// ---------------------------------------------------------------------

module rv_alu_unit
  import rv_alu_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_i,
  input  logic [INSTR_W-1:0] instr_i,
  input  logic [XLEN-1:0]    rs1_val_i,
  input  logic [XLEN-1:0]    rs2_val_i,
  input  logic               res_ack_i,
  output logic               ack_o,
  output logic               res_req_o,
  output logic [XLEN-1:0]    res_value_o,
  output logic [4:0]         res_rd_o,
  output logic               res_illegal_o
);

  // Decode to result exchange
  logic            iss_valid;
  logic            iss_taken;
  alu_op_e         iss_op;
  logic [XLEN-1:0] iss_a;
  logic [XLEN-1:0] iss_b;
  logic [4:0]      iss_rd;
  logic            iss_illegal;
  logic [XLEN-1:0] alu_value;

  rv_alu_decode #(.XLEN(XLEN)) u_decode (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_i         (req_i),
    .instr_i       (instr_i),
    .rs1_val_i     (rs1_val_i),
    .rs2_val_i     (rs2_val_i),
    .iss_taken_i   (iss_taken),
    .ack_o         (ack_o),
    .iss_valid_o   (iss_valid),
    .iss_op_o      (iss_op),
    .iss_a_o       (iss_a),
    .iss_b_o       (iss_b),
    .iss_rd_o      (iss_rd),
    .iss_illegal_o (iss_illegal)
  );

  riscv_alu #(.XLEN(XLEN)) u_alu (
    .alu_op_i     (iss_op),
    .alu_a_i      (iss_a),
    .alu_b_i      (iss_b),
    .alu_result_o (alu_value)
  );

  rv_alu_result #(.XLEN(XLEN)) u_result (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .iss_valid_i   (iss_valid),
    .alu_value_i   (alu_value),
    .iss_rd_i      (iss_rd),
    .iss_illegal_i (iss_illegal),
    .res_ack_i     (res_ack_i),
    .iss_taken_o   (iss_taken),
    .res_req_o     (res_req_o),
    .res_value_o   (res_value_o),
    .res_rd_o      (res_rd_o),
    .res_illegal_o (res_illegal_o)
  );

endmodule

/* rv_alu_unit_chk.sv */
// ----------------------------------------------------------------------
// Handshake checks for the execution slice bound to rv_alu_unit
// Assumes a single clock and the asynchronous active-low reset
// Payload width follows XLEN of the bound instance
// ----------------------------------------------------------------------

module rv_alu_unit_chk
#(
  parameter int XLEN = 32
) (
  input logic            clk_i,
  input logic            rst_n_i,
  input logic            req_i,
  input logic            ack_o,
  input logic            res_req_o,
  input logic            res_ack_i,
  input logic [XLEN-1:0] res_value_o
);

  // Upstream four-phase order
  a_ack_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(ack_o) |-> req_i) else $error("ack_o rose without req_i");
  a_ack_fall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(ack_o) |-> $past(!req_i)) else $error("ack_o fell before req_i dropped");

  // Downstream four-phase order and stable payload
  a_res_fall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(res_req_o) |-> $past(res_ack_i)) else $error("res_req_o fell without res_ack_i");
  a_res_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(res_req_o) |-> !res_ack_i) else $error("res_req_o rose while res_ack_i high");
  a_res_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_req_o && $past(res_req_o) |-> $stable(res_value_o)) else $error("res_value_o moved");

  a_reset: assert property (@(posedge clk_i)
    !rst_n_i |-> !ack_o && !res_req_o) else $error("Handshake high during reset");

endmodule

bind rv_alu_unit rv_alu_unit_chk #(.XLEN(XLEN)) u_chk (.*);

/* rv_alu_unit_tb.sv */
// ----------------------------------------------------------------------
// Table and random stimulus for rv_alu_unit with XLEN 32
// Source and sink run in parallel and results are compared in arrival order
// ----------------------------------------------------------------------

module rv_alu_unit_tb;

  localparam int TMO = 200;   // Cycles per wait
  localparam int N_RND = 40;
  localparam bit ACK_SIG = 1'b0;  // Upstream ack_o
  localparam bit RES_SIG = 1'b1;  // Downstream res_req_o

  typedef struct {
    string name;
    logic [31:0] instr, rs1, rs2, value;
    logic [4:0] rd;
    logic ill;
  } vec_t;

  logic clk_i = 1'b0;
  logic rst_n_i = 1'b1;       // Pulled low at time zero
  logic req_i = 1'b0;
  logic res_ack_i = 1'b0;
  logic [31:0] instr_i = '0;
  logic [31:0] rs1_val_i = '0;
  logic [31:0] rs2_val_i = '0;
  logic ack_o, res_req_o, res_illegal_o;
  logic [31:0] res_value_o;
  logic [4:0] res_rd_o;
  vec_t vecs[$], exp_q[$];
  logic [31:0] rng = 32'h7a11_e58d;
  int fails = 0;
  int timeouts = 0;
  int other = 0;
  int stalls = 0;
  int total = 0;
  int n_tab = 0;              // Table entries ahead of the random ones

  rv_alu_unit #(.XLEN(32)) uut (.*);

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  // Instruction with a 12-bit upper field (I-imm or funct7 + rs2 of zero)
  function automatic logic [31:0] enc(input logic [11:0] hi, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] opc);
    return {hi, 5'd0, f3, rd, opc};
  endfunction

  // Reference model from the RV32I rules
  function automatic vec_t predict(input string nm, input logic [31:0] ins, a, b_reg);
    vec_t v;
    logic [31:0] b;
    v = '{nm, ins, a, b_reg, 32'd0, ins[11:7], 1'b0};
    b = (ins[6:0] == 7'h33) ? b_reg : {{20{ins[31]}}, ins[31:20]};
    if (ins[6:0] == 7'h37)
      v.value = {ins[31:12], 12'd0};
    else if (ins[6:0] != 7'h33 && ins[6:0] != 7'h13)
    begin
      v.ill = 1'b1;   // Unknown opcode
      v.rd  = 5'd0;
    end
    else
      case (ins[14:12])
        3'd0: v.value = (ins[6:0] == 7'h33 && ins[30]) ? a - b : a + b;
        3'd1: v.value = a << b[4:0];
        3'd2: v.value = {31'd0, $signed(a) < $signed(b)};
        3'd3: v.value = {31'd0, a < b};
        3'd4: v.value = a ^ b;
        3'd5: v.value = ins[30] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6: v.value = a | b;
        default: v.value = a & b;
      endcase
    return v;
  endfunction

  // Waits at falling edges for ack_o or res_req_o to reach a level
  task automatic wait_level(input bit sel, input logic lvl, output int n);
    logic cur;
    n = 0;
    @(negedge clk_i);
    cur = (sel == RES_SIG) ? res_req_o : ack_o;
    while (cur !== lvl && n < TMO)
    begin
      @(negedge clk_i);
      n++;
      cur = (sel == RES_SIG) ? res_req_o : ack_o;
    end
    if (cur !== lvl)
    begin
      $display("Timeout: %s never went %0b", (sel == RES_SIG) ? "res_req_o" : "ack_o", lvl);
      timeouts++;
    end
  endtask

  task automatic send(input vec_t v);
    int n;
    exp_q.push_back(v);
    @(posedge clk_i);
    req_i     <= 1'b1;
    instr_i   <= v.instr;
    rs1_val_i <= v.rs1;
    rs2_val_i <= v.rs2;
    wait_level(ACK_SIG, 1'b1, n);
    if (n > 1)
      stalls++;   // Both stages were full
    @(posedge clk_i);
    req_i <= 1'b0;
    wait_level(ACK_SIG, 1'b0, n);
  endtask

  task automatic receive(input int delay);
    int n;
    vec_t e;
    wait_level(RES_SIG, 1'b1, n);
    if (timeouts != 0)
      return;
    e = exp_q.pop_front();
    if (res_value_o !== e.value)
    begin
      $display("Fail %s value expected %h actual %h", e.name, e.value, res_value_o);
      fails++;
    end
    if (res_rd_o !== e.rd || res_illegal_o !== e.ill)
    begin
      $display("Fail %s rd/illegal expected %0d/%0b actual %0d/%0b", e.name, e.rd, e.ill,
               res_rd_o, res_illegal_o);
      fails++;
    end
    repeat (delay) @(posedge clk_i);
    @(posedge clk_i) res_ack_i <= 1'b1;
    wait_level(RES_SIG, 1'b0, n);
    @(posedge clk_i) res_ack_i <= 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Stimulus table with hand-worked expected values
  // ----------------------------------------------------------------------
  initial
  begin
    rst_n_i <= 1'b0;
    vecs.push_back('{"add_wrap", enc(12'h000, 0, 1, 7'h33), 32'hFFFFFFFF, 2, 1, 1, 0});
    vecs.push_back('{"sub", enc(12'h400, 0, 2, 7'h33), 5, 7, 32'hFFFFFFFE, 2, 0});
    vecs.push_back('{"and", enc(0, 7, 3, 7'h33), 32'hF0F0F0F0, 32'hFF00FF00, 32'hF000F000, 3, 0});
    vecs.push_back('{"or", enc(0, 6, 4, 7'h33), 32'hF0F0F0F0, 32'h0F0F0000, 32'hFFFFF0F0, 4, 0});
    vecs.push_back('{"xor", enc(0, 4, 5, 7'h33), 32'hAAAAAAAA, 32'hFFFF0000, 32'h5555AAAA, 5, 0});
    vecs.push_back('{"addi_neg", enc(12'hFFF, 0, 6, 7'h13), 10, 0, 9, 6, 0});
    vecs.push_back('{"addi_f7", enc(12'h405, 0, 7, 7'h13), 100, 0, 32'h469, 7, 0});
    vecs.push_back('{"sll", enc(0, 1, 8, 7'h33), 3, 32'h21, 6, 8, 0});
    vecs.push_back('{"srl", enc(0, 5, 9, 7'h33), 32'h80000000, 32'h24, 32'h08000000, 9, 0});
    vecs.push_back('{"sra", enc(12'h400, 5, 10, 7'h33), 32'h80000000, 32'h24, 32'hF8000000, 10, 0});
    vecs.push_back('{"srai", enc(12'h408, 5, 11, 7'h13), 32'hF0000000, 0, 32'hFFF00000, 11, 0});
    vecs.push_back('{"slli", enc(12'h005, 1, 12, 7'h13), 32'h80000001, 0, 32'h00000020, 12, 0});
    vecs.push_back('{"srli", enc(12'h01F, 5, 13, 7'h13), 32'h80000000, 0, 1, 13, 0});
    vecs.push_back('{"slt", enc(0, 2, 14, 7'h33), 32'hFFFFFFFF, 1, 1, 14, 0});
    vecs.push_back('{"sltu", enc(0, 3, 15, 7'h33), 32'hFFFFFFFF, 1, 0, 15, 0});
    vecs.push_back('{"lui", 32'hABCDE937, 0, 0, 32'hABCDE000, 18, 0});
    vecs.push_back('{"illegal", 32'h000009FF, 7, 9, 0, 0, 1});
    vecs.push_back('{"after_illegal", enc(0, 0, 20, 7'h33), 1, 2, 3, 20, 0});
    n_tab = vecs.size();
    for (int i = 0; i < N_RND; i++)
    begin
      logic [31:0] ins;
      logic        alt;
      rng = xorshift(rng);
      ins = rng;
      ins[6:0] = rng[0] ? 7'h33 : 7'h13;   // OP or OP-IMM
      // funct7 stays zero apart from bit 30 on SUB, SRA and SRAI
      alt = ins[30] && (ins[14:12] == 3'd5 || (ins[6:0] == 7'h33 && ins[14:12] == 3'd0));
      if (ins[6:0] == 7'h33 || ins[13:12] == 2'b01)
        ins[31:25] = {1'b0, alt, 5'd0};
      rng = xorshift(rng);
      vecs.push_back(predict($sformatf("rnd_%0d", i), ins, rng, xorshift(rng)));
      rng = xorshift(rng);
    end
    total = vecs.size();
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    fork
      foreach (vecs[i])
        if (timeouts == 0)
          send(vecs[i]);
      for (int k = 0; k < total && timeouts == 0; k++)
        receive(k < n_tab ? 0 : int'(xorshift(rng + k) % 7));
    join
    if (stalls == 0)
    begin
      $display("Source never saw ack_o withheld under back-pressure");
      other++;
    end
    $display("Errors: %0d mismatches, %0d timeouts, %0d other", fails, timeouts, other);
    if (fails == 0 && timeouts == 0 && other == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule
